// ==== isa_pkg.sv ====
// instruction set constants, opcode enum and opcode legality check shared by the pipeline stages
package isa_pkg;

    localparam int word_w   = 32;                   // data and address width
    localparam int opcode_w = 6;                    // top field of every instruction
    localparam int op_msb   = word_w - 1;           // opcode field upper bit
    localparam int op_lsb   = word_w - opcode_w;    // opcode field lower bit

    // all-zero word decodes as op_nop
    localparam logic [word_w-1:0] isa_nop = '0;     // bubble inserted on flush

    typedef enum logic [opcode_w-1:0] {
        op_nop    = 6'd0,                           // no operation
        op_alu    = 6'd1,                           // register-register alu
        op_addi   = 6'd2,                           // add immediate
        op_load   = 6'd3,                           // word load
        op_store  = 6'd4,                           // word store
        op_branch = 6'd5,                           // conditional branch, has delay slot
        op_jump   = 6'd6,                           // unconditional jump
        op_halt   = 6'd7                            // stop the core
    } opcode_e;

    // 1 when the field matches one of the opcode_e values
    function automatic logic opcode_legal(input logic [opcode_w-1:0] field);
        logic legal;
        case (field)
            op_nop,
            op_alu,
            op_addi,
            op_load,
            op_store,
            op_branch,
            op_jump,
            op_halt:
            begin
                legal = 1'b1;                       // known encoding
            end
            default:
            begin
                legal = 1'b0;                       // reserved encodings
            end
        endcase
        return legal;
    endfunction

endpackage

// ==== fetch_pkg.sv ====
// fetch stage sizes, reset pc, packet and memory write structs and skid buffer states
package fetch_pkg;

    localparam int mem_words  = 64;                          // instruction memory depth
    localparam int mem_aw     = $clog2(mem_words);           // word index width
    localparam int pc_idx_lsb = 2;                           // pc is word aligned

    localparam logic [isa_pkg::word_w-1:0] reset_pc = '0;    // first fetch address
    localparam logic [isa_pkg::word_w-1:0] pc_step  = 32'd4; // sequential increment

    // one fetched instruction with its address and predecode
    typedef struct packed {
        logic [isa_pkg::word_w-1:0] pc;                      // instruction address
        logic [isa_pkg::word_w-1:0] insn;                    // raw word
        isa_pkg::opcode_e           op;                      // top field as enum
        logic                       illegal;                 // opcode not in enum
    } fetch_pkt_t;

    // program load port of the instruction memory
    typedef struct packed {
        logic                       we;                      // write strobe
        logic [mem_aw-1:0]          addr;                    // word index
        logic [isa_pkg::word_w-1:0] data;                    // word to store
    } mem_wr_t;

    // occupancy of the skid buffer
    typedef enum logic [1:0] {
        st_empty = 2'd0,                                     // nothing held
        st_one   = 2'd1,                                     // head only
        st_two   = 2'd2                                      // head and second, stall
    } skid_state_e;

endpackage

// ==== insn_mem.sv ====
// instruction memory read by the fetch pc and loaded through a synchronous write port
`timescale 1ns/10ps

module insn_mem (
    input  logic                         clk,
    input  fetch_pkg::mem_wr_t           prog,      // load port
    input  logic [isa_pkg::word_w-1:0]   fetch_pc,  // byte address from if_reg
    output logic [isa_pkg::word_w-1:0]   rd_insn    // word at fetch_pc
);

    logic [isa_pkg::word_w-1:0] mem [fetch_pkg::mem_words];  // program storage
    logic [fetch_pkg::mem_aw-1:0] rd_idx;                    // word index of fetch_pc

    // bits above the index are ignored so the pc wraps over the array
    assign rd_idx = fetch_pc[fetch_pkg::pc_idx_lsb +: fetch_pkg::mem_aw];

    // async read, same cycle as the pc
    assign rd_insn = mem[rd_idx];

    // load at clock edge
    always_ff @(posedge clk)
    begin
        if (prog.we)
        begin
            mem[prog.addr] <= prog.data;                     // one word per cycle
        end
    end

endmodule

// ==== if_reg.sv ====
// pc generation and IF/ID pipeline register with stall, flush, delayed branch and predecode
`timescale 1ns/10ps

module if_reg (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         stall,     // back-pressure from skid buffer
    input  logic                         flush,     // exception or restart strobe
    input  logic [isa_pkg::word_w-1:0]   new_pc,    // flush target
    input  logic                         br_taken,  // branch strobe
    input  logic [isa_pkg::word_w-1:0]   br_addr,   // branch target
    input  logic [isa_pkg::word_w-1:0]   rd_insn,   // word at fetch_pc
    output logic [isa_pkg::word_w-1:0]   fetch_pc,  // address to memory
    output fetch_pkg::fetch_pkt_t        if_pkt,    // IF/ID register
    output logic                         if_valid   // if_pkt holds a real instruction
);

    logic [isa_pkg::word_w-1:0] pc_q;         // current fetch address
    logic                       pend_q;       // branch seen during stall
    logic [isa_pkg::word_w-1:0] pend_addr_q;  // its target
    logic                       redirect;     // take a branch target this advance
    logic [isa_pkg::word_w-1:0] redirect_pc;  // chosen branch target
    logic [isa_pkg::word_w-1:0] next_pc;      // pc after an advancing cycle
    isa_pkg::opcode_e           dec_op;       // predecoded opcode
    logic                       dec_illegal;  // opcode outside the enum
    fetch_pkg::fetch_pkt_t      cap_pkt;      // packet for the current pc

    assign fetch_pc = pc_q;

    // fresh strobe beats a stored one
    assign redirect    = br_taken || pend_q;
    assign redirect_pc = br_taken ? br_addr : pend_addr_q;
    assign next_pc     = redirect ? redirect_pc : pc_q + fetch_pkg::pc_step;

    // predecode of the top field
    assign dec_op      = isa_pkg::opcode_e'(rd_insn[isa_pkg::op_msb:isa_pkg::op_lsb]);
    assign dec_illegal = !isa_pkg::opcode_legal(rd_insn[isa_pkg::op_msb:isa_pkg::op_lsb]);

    always_comb
    begin
        cap_pkt.pc      = pc_q;         // address of this word
        cap_pkt.insn    = rd_insn;
        cap_pkt.op      = dec_op;
        cap_pkt.illegal = dec_illegal;
    end

    // pc, IF/ID register and pending flag
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc_q     <= fetch_pkg::reset_pc;
            if_pkt   <= '{pc: fetch_pkg::reset_pc, insn: isa_pkg::isa_nop,
                          op: isa_pkg::op_nop, illegal: 1'b0};
            if_valid <= 1'b0;
            pend_q   <= 1'b0;
        end
        else if (flush)
        begin
            // acts even while stalled, fetch in progress becomes a bubble
            pc_q     <= new_pc;
            if_pkt   <= '{pc: new_pc, insn: isa_pkg::isa_nop,
                          op: isa_pkg::op_nop, illegal: 1'b0};
            if_valid <= 1'b0;
            pend_q   <= 1'b0;   // stored branch dies with the flush
        end
        else if (!stall)
        begin
            pc_q     <= next_pc;   // target or pc+4
            if_pkt   <= cap_pkt;   // delay slot when redirecting
            if_valid <= 1'b1;
            pend_q   <= 1'b0;      // pending target consumed
        end
        else if (br_taken)
        begin
            pend_q   <= 1'b1;      // keep branch until stall drops
        end
    end

    // target of a branch that arrived while stalled
    always_ff @(posedge clk)
    begin
        if (stall && br_taken)
        begin
            pend_addr_q <= br_addr;   // latest strobe wins
        end
    end

endmodule

// ==== if_skid.sv ====
// two-entry skid buffer turning the IF register output into a valid/ready stream with stall
`timescale 1ns/10ps

module if_skid (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush,      // drop everything buffered
    input  fetch_pkg::fetch_pkt_t  in_pkt,     // from IF/ID register
    input  logic                   in_valid,
    output logic                   stall,      // holds the IF register
    output fetch_pkg::fetch_pkt_t  out_pkt,    // to decode
    output logic                   out_valid,
    input  logic                   out_ready
);

    fetch_pkg::skid_state_e state_q;    // occupancy
    fetch_pkg::skid_state_e state_d;
    fetch_pkg::fetch_pkt_t  head_q;     // drives the output
    fetch_pkg::fetch_pkt_t  second_q;   // packet in flight when decode stops
    logic                   push;       // if_reg advances into the buffer
    logic                   pop;        // decode takes the head

    // IF register only advances when not stalled, so each packet is pushed once
    assign push = in_valid && !stall;
    assign pop  = out_valid && out_ready;

    assign out_valid = (state_q != fetch_pkg::st_empty);
    assign stall     = (state_q == fetch_pkg::st_two);   // full, stop fetch
    assign out_pkt   = head_q;

    // occupancy FSM
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            fetch_pkg::st_empty:
            begin
                if (push)
                    state_d = fetch_pkg::st_one;
            end
            fetch_pkg::st_one:
            begin
                if (push && !pop)
                    state_d = fetch_pkg::st_two;    // consumer stopped
                else if (!push && pop)
                    state_d = fetch_pkg::st_empty;
            end
            fetch_pkg::st_two:
            begin
                if (pop)
                    state_d = fetch_pkg::st_one;    // second moves up
            end
            default:
            begin
                state_d = fetch_pkg::st_empty;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state_q <= fetch_pkg::st_empty;
        else if (flush)
            state_q <= fetch_pkg::st_empty;     // same edge as the flush
        else
            state_q <= state_d;
    end

    // data path, head only changes on pop or when empty
    always_ff @(posedge clk)
    begin
        if ((state_q == fetch_pkg::st_empty && push) ||
            (state_q == fetch_pkg::st_one && push && pop))
            head_q <= in_pkt;                   // straight to head
        else if (state_q == fetch_pkg::st_two && pop)
            head_q <= second_q;
        if (state_q == fetch_pkg::st_one && push && !pop)
            second_q <= in_pkt;                 // absorb in-flight packet
    end

endmodule

// ==== fetch_stage.sv ====
// fetch stage top joining instruction memory, IF/ID register and skid buffer
`timescale 1ns/10ps

module fetch_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    input  fetch_pkg::mem_wr_t           prog,       // memory load port
    input  logic                         br_taken,   // branch strobe
    input  logic [isa_pkg::word_w-1:0]   br_addr,
    input  logic                         flush,      // flush strobe
    input  logic [isa_pkg::word_w-1:0]   new_pc,
    output fetch_pkg::fetch_pkt_t        out_pkt,    // stream to decode
    output logic                         out_valid,
    input  logic                         out_ready
);

    logic [isa_pkg::word_w-1:0] fetch_pc;   // if_reg to memory
    logic [isa_pkg::word_w-1:0] rd_insn;    // memory to if_reg, same cycle
    fetch_pkg::fetch_pkt_t      if_pkt;     // IF/ID register contents
    logic                       if_valid;
    logic                       stall;      // buffer full

    insn_mem i_mem (
        .clk      (clk),
        .prog     (prog),
        .fetch_pc (fetch_pc),
        .rd_insn  (rd_insn)
    );

    if_reg i_if_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .flush    (flush),
        .new_pc   (new_pc),
        .br_taken (br_taken),
        .br_addr  (br_addr),
        .rd_insn  (rd_insn),
        .fetch_pc (fetch_pc),
        .if_pkt   (if_pkt),
        .if_valid (if_valid)
    );

    if_skid i_skid (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_pkt    (if_pkt),
        .in_valid  (if_valid),
        .stall     (stall),
        .out_pkt   (out_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

// ==== fetch_stage_sva.sv ====
// concurrent checks on the fetch stage output handshake and reset values, attached with bind
`timescale 1ns/10ps

module fetch_stage_sva (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  flush,
    input logic                  stall,       // internal buffer-full signal
    input fetch_pkg::fetch_pkt_t out_pkt,
    input logic                  out_valid,
    input logic                  out_ready
);

    int n_fail = 0;                           // failed assertion count

    // nothing offered and fetch not held while in reset
    reset_idle: assert property (@(posedge clk) !rst_n |-> !out_valid && !stall)
        else
        begin
            n_fail++;
            $error("out_valid or stall high during reset");
        end

    // offered packet waits unchanged for the consumer
    hold_pkt: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready && !flush |=> out_valid && $stable(out_pkt))
        else
        begin
            n_fail++;
            $error("out_pkt changed or was dropped before transfer");
        end

endmodule

bind fetch_stage fetch_stage_sva i_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .stall     (stall),
    .out_pkt   (out_pkt),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

// ==== tb_fetch_stage.sv ====
// testbench for the fetch stage, runs the program and command script read from fetch_input.txt
`timescale 1ns/10ps

module tb_fetch_stage;

    localparam int wait_limit  = 16;                 // cycles allowed for any one wait
    localparam int reset_hold  = 10;                 // reset cycles after the memory load

    logic                        clk   = 1'b1;
    logic                        rst_n = 1'b1;
    fetch_pkg::mem_wr_t          prog;
    logic                        br_taken;
    logic [isa_pkg::word_w-1:0]  br_addr;
    logic                        flush;
    logic [isa_pkg::word_w-1:0]  new_pc;
    fetch_pkg::fetch_pkt_t       out_pkt;
    logic                        out_valid;
    logic                        out_ready;

    logic [isa_pkg::word_w-1:0]  mem_img [fetch_pkg::mem_words];  // expected memory contents
    int                          ph_cycles [$];      // phase length
    int                          ph_ready [$];       // ready percentage
    int                          ph_kind [$];        // 0 none, 1 branch, 2 flush
    int                          ph_off [$];         // cycle of the event in the phase
    logic [isa_pkg::word_w-1:0]  ph_target [$];      // branch or flush target

    fetch_pkg::fetch_pkt_t       exp_q [$];          // packets inside the buffer, in order
    logic [isa_pkg::word_w-1:0]  m_pc;               // model fetch pc
    logic                        m_valid;            // model IF register holds a packet
    fetch_pkg::fetch_pkt_t       m_pkt;              // model IF register contents
    logic                        m_pend;             // branch seen while stalled
    logic [isa_pkg::word_w-1:0]  m_pend_addr;
    int                          n_checked;          // transfers compared
    int                          n_illegal;          // of those, illegal opcodes
    logic [31:0]                 rng_state;

    fetch_stage i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog      (prog),
        .br_taken  (br_taken),
        .br_addr   (br_addr),
        .flush     (flush),
        .new_pc    (new_pc),
        .out_pkt   (out_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #50 clk = ~clk;                           // 100 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // default program word, every index gets its own value
    function automatic logic [31:0] fill_word(input int idx);
        return {6'(1 + idx % 3), 20'(idx * 945), 6'(idx)};
    endfunction

    // packet fetched at pc, opcodes 0 to 7 are defined, all others illegal
    function automatic fetch_pkg::fetch_pkt_t expect_pkt(input logic [31:0] pc);
        fetch_pkg::fetch_pkt_t pkt;
        logic [31:0]           insn;
        insn        = mem_img[pc[7:2]];              // pc bits 7:2 pick the word
        pkt.pc      = pc;
        pkt.insn    = insn;
        pkt.op      = isa_pkg::opcode_e'(insn[31:26]);
        pkt.illegal = (insn[31:26] > 6'd7);
        return pkt;
    endfunction

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic give_up(input string why);
        $display("timeout: %s", why);
        abort_run();
    endtask

    // bound checker counts its assertion failures
    task automatic stop_on_assertion();
        if (i_dut.i_sva.n_fail != 0)
        begin
            $display("a bound assertion on the fetch stage output failed");
            abort_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("FAILED at %0d ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pkt(input fetch_pkg::fetch_pkt_t got, input fetch_pkg::fetch_pkt_t exp);
        if (got !== exp)
        begin
            $display("FAILED at %0d ns: packet pc %h insn %h op %0d illegal %b,", $time,
                     got.pc, got.insn, got.op, got.illegal);
            $display("    expected pc %h insn %h op %0d illegal %b",
                     exp.pc, exp.insn, exp.op, exp.illegal);
            abort_run();
        end
    endtask

    // parse program words and phases, see the column note at the top of the file
    task automatic read_input();
        int          fd;
        int          n;
        string       line;
        int          idx;
        logic [31:0] word;
        int          cyc;
        int          pct;
        int          kind;
        int          off;
        logic [31:0] tgt;
        fd = $fopen("fetch_input.txt", "r");
        if (fd == 0)
        begin
            $display("could not open fetch_input.txt");
            abort_run();
        end
        else
        begin
            while (!$feof(fd))
            begin
                n = $fgets(line, fd);
                if (n > 1 && line[0] == "m")
                begin
                    n = $sscanf(line, "m %h %h", idx, word);
                    mem_img[idx] = word;             // overrides the fill pattern
                end
                else if (n > 1 && line[0] == "p")
                begin
                    n = $sscanf(line, "p %d %d %d %d %h", cyc, pct, kind, off, tgt);
                    ph_cycles.push_back(cyc);
                    ph_ready.push_back(pct);
                    ph_kind.push_back(kind);
                    ph_off.push_back(off);
                    ph_target.push_back(tgt);
                end
            end
            $fclose(fd);
        end
    endtask

    // one cycle, called at the falling edge, returns at the next falling edge
    task automatic run_cycle(input logic rdy, input logic br, input logic fl,
                             input logic [31:0] tgt);
        logic m_stall;
        out_ready = rdy;
        br_taken  = br;
        br_addr   = br ? tgt : '0;
        flush     = fl;
        new_pc    = fl ? tgt : '0;
        m_stall   = (exp_q.size() == 2);             // two buffered, fetch held
        check_bit(out_valid, exp_q.size() != 0, "out_valid");
        if (out_valid && rdy)
        begin
            check_pkt(out_pkt, exp_q[0]);            // transfer at the coming edge
            if (exp_q[0].illegal)
                n_illegal++;
            exp_q.pop_front();
            n_checked++;
        end
        if (fl)
        begin
            exp_q.delete();                          // buffer and fetch in progress dropped
            m_pc    = tgt;
            m_valid = 1'b0;
            m_pend  = 1'b0;
        end
        else if (!m_stall)
        begin
            if (m_valid)
                exp_q.push_back(m_pkt);
            m_pkt   = expect_pkt(m_pc);              // delay slot when redirecting
            m_pc    = br ? tgt : (m_pend ? m_pend_addr : m_pc + 32'd4);
            m_valid = 1'b1;
            m_pend  = 1'b0;
        end
        else if (br)
        begin
            m_pend      = 1'b1;                      // applied at the next advance
            m_pend_addr = tgt;
        end
        @(posedge clk);
        @(negedge clk);
        stop_on_assertion();
    endtask

    initial
    begin
        int   i;
        int   p;
        int   c;
        int   waited;
        int   target;
        logic rdy;
        prog      = '0;
        br_taken  = 1'b0;
        br_addr   = '0;
        flush     = 1'b0;
        new_pc    = '0;
        out_ready = 1'b0;
        rng_state = 32'h899f_cabd;
        n_checked = 0;
        n_illegal = 0;
        for (i = 0; i < fetch_pkg::mem_words; i++)
            mem_img[i] = fill_word(i);
        read_input();

        // load the program with the fetch stage held in reset
        @(negedge clk);
        rst_n = 1'b0;
        for (i = 0; i < fetch_pkg::mem_words; i++)
        begin
            prog = '{we: 1'b1, addr: 6'(i), data: mem_img[i]};
            @(posedge clk);
            @(negedge clk);
            check_bit(out_valid, 1'b0, "out_valid in reset");
            stop_on_assertion();
        end
        prog = '0;
        for (i = 0; i < reset_hold; i++)
        begin
            @(posedge clk);
            @(negedge clk);
            check_bit(out_valid, 1'b0, "out_valid in reset");
            stop_on_assertion();
        end
        rst_n   = 1'b1;
        m_pc    = fetch_pkg::reset_pc;
        m_valid = 1'b0;
        m_pend  = 1'b0;

        waited = 0;
        while (!out_valid)
        begin
            if (waited >= wait_limit)
                give_up("no packet came out after reset");
            else
            begin
                run_cycle(1'b1, 1'b0, 1'b0, '0);
                waited++;
            end
        end

        for (p = 0; p < ph_cycles.size(); p++)
        begin
            for (c = 0; c < ph_cycles[p]; c++)
            begin
                rng_state = xorshift32(rng_state);
                rdy       = ((rng_state % 100) < ph_ready[p]);
                run_cycle(rdy, ph_kind[p] == 1 && c == ph_off[p],
                          ph_kind[p] == 2 && c == ph_off[p], ph_target[p]);
            end
        end

        // take what is still buffered
        target = n_checked + exp_q.size();
        waited = 0;
        while (n_checked < target)
        begin
            if (waited >= wait_limit)
                give_up("buffered packets did not drain");
            else
            begin
                run_cycle(1'b1, 1'b0, 1'b0, '0);
                waited++;
            end
        end

        if (n_illegal == 0)
        begin
            $display("no packet with an illegal opcode reached the output");
            abort_run();
        end
        else
        begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== fetch_input.txt ====
# m <word index hex> <instruction word hex>, unlisted words use the testbench fill pattern
# p <cycles> <ready percent> <event 0 none 1 branch 2 flush> <event cycle> <target pc hex>
# program words, opcode is bits 31:26, values above 7 are illegal
m 00 08000000
m 01 04210001
m 02 14000010
m 03 20000003
m 04 0c410004
m 05 fc00ffff
m 06 10220006
m 07 18000040
m 08 00000000
m 09 1c000000
m 0a 54abcdef
m 0b 08000b0b
m 0c 0c000c0c
m 10 40001010
m 11 04211111
m 1f 9c001f1f
m 20 14000000
m 21 80000021
m 22 08001022
m 23 0c002323
m 24 10002424
m 28 18002828
m 29 f8002929
m 30 04003030
m 3c 04213c3c
m 3d 0c003d3d
m 3e e0003e3e
m 3f 1c00003f
# straight run from pc 0
p 20 100 0 0 00000000
# random back-pressure
p 40 60 0 0 00000000
# branch strobe while the buffer is full
p 8 0 1 5 00000080
p 12 100 0 0 00000000
# branch without stall, target near the top of memory
p 10 100 1 3 000000f0
p 20 100 0 0 00000000
# flush to a high pc, index wraps with the upper bits kept
p 6 40 2 2 000010f0
p 20 70 0 0 00000000
# flush while stalled
p 10 0 2 6 00000014
p 16 100 0 0 00000000
# branch under random ready
p 30 50 1 10 00000028
p 70 80 0 0 00000000
p 30 30 0 0 00000000

// ==== files.f ====
isa_pkg.sv
fetch_pkg.sv
insn_mem.sv
if_reg.sv
if_skid.sv
fetch_stage.sv
fetch_stage_sva.sv
tb_fetch_stage.sv
